//--- soc_consts.svh
//****************************************
// Board glue constants shared by the RTL and the testbench
// Table words are 32 bits; slot order follows soc_pkg::dev_slot_e
//****************************************
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Default countdown widths, both overridable per instance
`define RST_CNTR_BITSZ      20
`define RAM_RST_CNTR_BITSZ  20

// Dimming counter for the activity LED
`define ACTIVITY_CNTR_BITSZ 1

`define GPIOCOUNT 8

// Device identifiers per slot
`define DEVTBL_ID_SDCARD     32'd4
`define DEVTBL_ID_DEVTBL     32'd7
`define DEVTBL_ID_GPIO       32'd6
`define DEVTBL_ID_DMA        32'd2
`define DEVTBL_ID_INTCTRL    32'd3
`define DEVTBL_ID_UART       32'd5
`define DEVTBL_ID_RAM        32'd1
`define DEVTBL_ID_RAMCTRL    32'd0
`define DEVTBL_ID_BOOTLDR    32'd0
`define DEVTBL_ID_INVALIDDEV 32'd0

// Map sizes in bytes, RAM is 1GB
`define DEVTBL_MAPSZ_SDCARD     32'h0000_1000
`define DEVTBL_MAPSZ_DEVTBL     32'h0000_1000
`define DEVTBL_MAPSZ_GPIO       32'h0000_1000
`define DEVTBL_MAPSZ_DMA        32'h0000_1000
`define DEVTBL_MAPSZ_INTCTRL    32'h0000_1000
`define DEVTBL_MAPSZ_UART       32'h0000_1000
`define DEVTBL_MAPSZ_RAM        32'h4000_0000
`define DEVTBL_MAPSZ_RAMCTRL    32'h0001_0000
`define DEVTBL_MAPSZ_BOOTLDR    32'h0000_1000
`define DEVTBL_MAPSZ_INVALIDDEV 32'h0000_1000

// Interrupt use per slot
`define DEVTBL_USEINTR_SDCARD     1'b1
`define DEVTBL_USEINTR_DEVTBL     1'b0
`define DEVTBL_USEINTR_GPIO       1'b1
`define DEVTBL_USEINTR_DMA        1'b1
`define DEVTBL_USEINTR_INTCTRL    1'b0
`define DEVTBL_USEINTR_UART       1'b1
`define DEVTBL_USEINTR_RAM        1'b0
`define DEVTBL_USEINTR_RAMCTRL    1'b0
`define DEVTBL_USEINTR_BOOTLDR    1'b0
`define DEVTBL_USEINTR_INVALIDDEV 1'b0

`endif

//--- soc_pkg.sv
//****************************************
// Types shared across the board glue logic
// Slot indices above SLOT_INVALIDDEV may still appear on a port
//****************************************
package soc_pkg;

	// Software reset request, bit 1 is rst1 and bit 0 is rst0
	typedef enum logic [1:0] {
		SWRST_NONE   = 2'b00,
		SWRST_PWROFF = 2'b01,
		SWRST_WARM   = 2'b10,
		SWRST_COLD   = 2'b11
	} swrst_e;

	// Peripheral slot index in the device table
	typedef enum logic [3:0] {
		SLOT_SDCARD     = 4'd0,
		SLOT_DEVTBL     = 4'd1,
		SLOT_GPIO       = 4'd2,
		SLOT_DMA        = 4'd3,
		SLOT_INTCTRL    = 4'd4,
		SLOT_UART       = 4'd5,
		SLOT_RAM        = 4'd6,
		SLOT_RAMCTRL    = 4'd7,
		SLOT_BOOTLDR    = 4'd8,
		// Default slot that catches accesses outside the map
		SLOT_INVALIDDEV = 4'd9
	} dev_slot_e;

endpackage

//--- rst_sequencer.sv
//****************************************
// System reset stays high for 2^rst_cntr_bits-1 edges after release
// RAM reset runs once per external reset and needs a locked PLL
// Power-off holds system reset until rst_p without the power-off code
//****************************************
`include "soc_consts.svh"

module rst_sequencer #(
	parameter int rst_cntr_bits     = `RST_CNTR_BITSZ,
	parameter int ram_rst_cntr_bits = `RAM_RST_CNTR_BITSZ
) (
	input  logic            clk200mhz_w,
	input  logic            rst_p,
	input  logic            pll_locked_i,
	input  soc_pkg::swrst_e swrst_i,
	input  logic            cpu_rst_req_i,
	output logic            sys_rst_o,
	output logic            ram_rst_o,
	output logic            gsr_o
);

	import soc_pkg::*;

	logic                           sw_pwroff_w;
	logic                           sw_warm_w;
	logic                           sw_cold_w;
	logic                           sys_reload_w;
	logic [rst_cntr_bits-1:0]       rst_cntr_q;
	logic [ram_rst_cntr_bits-1:0]   ram_rst_cntr_q;
	logic                           pwroff_q;

	// Software reset code decode
	assign sw_pwroff_w = (swrst_i == SWRST_PWROFF);
	assign sw_warm_w   = (swrst_i == SWRST_WARM);
	assign sw_cold_w   = (swrst_i == SWRST_COLD);

	// Any of these restarts the system countdown from the top
	assign sys_reload_w = rst_p || cpu_rst_req_i || sw_warm_w;

	always_ff @(posedge clk200mhz_w) begin
		if (sys_reload_w) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off latch, a pending request wins over the clear
	always_ff @(posedge clk200mhz_w) begin
		if (sw_pwroff_w) begin
			pwroff_q <= 1'b1;
		end else if (rst_p) begin
			pwroff_q <= 1'b0;
		end
	end

	// RAM reset timer
	// Only the external reset restarts it, so the RAM contents
	// survive warm and CPU requested resets
	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			ram_rst_cntr_q <= '1;
		end else if (pll_locked_i && (ram_rst_cntr_q != '0)) begin
			ram_rst_cntr_q <= ram_rst_cntr_q - 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr_q != '0) || !pll_locked_i || pwroff_q;
	assign ram_rst_o = (ram_rst_cntr_q != '0);

	// Global set/reset request follows the cold code directly
	assign gsr_o = sw_cold_w;

endmodule

//--- activity_blinker.sv
//****************************************
// LED pulse is one cycle, then held off for the dimming count
// The LED is ORed onto GPIO line 0 only
//****************************************
`include "soc_consts.svh"

module activity_blinker (
	input  logic                  clk200mhz_w,
	input  logic                  rst_p,
	input  logic                  sd_di_i,
	input  logic                  sd_do_i,
	input  logic                  dram_init_err_i,
	input  logic [`GPIOCOUNT-1:0] gpio_i,
	output logic [`GPIOCOUNT-1:0] gp_o
);

	logic                            trig_w;
	logic                            led_q;
	logic [`ACTIVITY_CNTR_BITSZ-1:0] dim_cntr_q;

	// SD lines idle high, any low counts as traffic
	assign trig_w = !(sd_di_i && sd_do_i) || dram_init_err_i;

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p) begin
			led_q      <= 1'b0;
			dim_cntr_q <= '0;
		end else if (dim_cntr_q != '0) begin
			// Off phase lowers the average brightness
			led_q      <= 1'b0;
			dim_cntr_q <= dim_cntr_q - 1'b1;
		end else if (trig_w) begin
			led_q      <= 1'b1;
			dim_cntr_q <= '1;
		end
	end

	assign gp_o = gpio_i | {{(`GPIOCOUNT-1){1'b0}}, led_q};

endmodule

//--- devtbl_rom.sv
//****************************************
// One read per strobe, result valid on the following edge
// Reads during system reset are dropped without a valid pulse
//****************************************
`include "soc_consts.svh"

module devtbl_rom (
	input  logic               clk200mhz_w,
	input  logic               rst_p,
	input  logic               sys_rst_i,
	input  logic               rd_i,
	input  soc_pkg::dev_slot_e slot_i,
	output logic               vld_o,
	output logic [31:0]        id_o,
	output logic               useintr_o,
	output logic [31:0]        mapsz_o
);

	import soc_pkg::*;

	logic        rd_ok_w;
	logic [31:0] sel_id_w;
	logic        sel_useintr_w;
	logic [31:0] sel_mapsz_w;

	assign rd_ok_w = rd_i && !sys_rst_i && !rst_p;

	// Table lookup, unlisted indices land on the invalid device
	always_comb begin
		case (slot_i)
			SLOT_SDCARD: begin
				sel_id_w      = `DEVTBL_ID_SDCARD;
				sel_useintr_w = `DEVTBL_USEINTR_SDCARD;
				sel_mapsz_w   = `DEVTBL_MAPSZ_SDCARD;
			end
			SLOT_DEVTBL: begin
				sel_id_w      = `DEVTBL_ID_DEVTBL;
				sel_useintr_w = `DEVTBL_USEINTR_DEVTBL;
				sel_mapsz_w   = `DEVTBL_MAPSZ_DEVTBL;
			end
			SLOT_GPIO: begin
				sel_id_w      = `DEVTBL_ID_GPIO;
				sel_useintr_w = `DEVTBL_USEINTR_GPIO;
				sel_mapsz_w   = `DEVTBL_MAPSZ_GPIO;
			end
			SLOT_DMA: begin
				sel_id_w      = `DEVTBL_ID_DMA;
				sel_useintr_w = `DEVTBL_USEINTR_DMA;
				sel_mapsz_w   = `DEVTBL_MAPSZ_DMA;
			end
			SLOT_INTCTRL: begin
				sel_id_w      = `DEVTBL_ID_INTCTRL;
				sel_useintr_w = `DEVTBL_USEINTR_INTCTRL;
				sel_mapsz_w   = `DEVTBL_MAPSZ_INTCTRL;
			end
			SLOT_UART: begin
				sel_id_w      = `DEVTBL_ID_UART;
				sel_useintr_w = `DEVTBL_USEINTR_UART;
				sel_mapsz_w   = `DEVTBL_MAPSZ_UART;
			end
			SLOT_RAM: begin
				sel_id_w      = `DEVTBL_ID_RAM;
				sel_useintr_w = `DEVTBL_USEINTR_RAM;
				sel_mapsz_w   = `DEVTBL_MAPSZ_RAM;
			end
			SLOT_RAMCTRL: begin
				sel_id_w      = `DEVTBL_ID_RAMCTRL;
				sel_useintr_w = `DEVTBL_USEINTR_RAMCTRL;
				sel_mapsz_w   = `DEVTBL_MAPSZ_RAMCTRL;
			end
			SLOT_BOOTLDR: begin
				sel_id_w      = `DEVTBL_ID_BOOTLDR;
				sel_useintr_w = `DEVTBL_USEINTR_BOOTLDR;
				sel_mapsz_w   = `DEVTBL_MAPSZ_BOOTLDR;
			end
			default: begin
				sel_id_w      = `DEVTBL_ID_INVALIDDEV;
				sel_useintr_w = `DEVTBL_USEINTR_INVALIDDEV;
				sel_mapsz_w   = `DEVTBL_MAPSZ_INVALIDDEV;
			end
		endcase
	end

	always_ff @(posedge clk200mhz_w) begin
		if (rst_p || sys_rst_i) begin
			vld_o <= 1'b0;
		end else begin
			vld_o <= rd_i;
		end
	end

	// Entry stays on the outputs until the next accepted read
	always_ff @(posedge clk200mhz_w) begin
		if (rd_ok_w) begin
			id_o      <= sel_id_w;
			useintr_o <= sel_useintr_w;
			mapsz_o   <= sel_mapsz_w;
		end
	end

endmodule

//--- soc_ctrl_top.sv
//****************************************
// Single clock domain, the PLL is reduced to pll_locked_i
// Device table is held off while sys_rst_o is high
//****************************************
`include "soc_consts.svh"

module soc_ctrl_top #(
	parameter int rst_cntr_bits     = `RST_CNTR_BITSZ,
	parameter int ram_rst_cntr_bits = `RAM_RST_CNTR_BITSZ
) (
	input  logic                  clk200mhz_w,
	input  logic                  rst_p,
	input  logic                  pll_locked_i,
	input  soc_pkg::swrst_e       swrst_i,
	input  logic                  cpu_rst_req_i,
	input  logic                  sd_di_i,
	input  logic                  sd_do_i,
	input  logic                  dram_init_err_i,
	input  logic [`GPIOCOUNT-1:0] gpio_i,
	input  logic                  devtbl_rd_i,
	input  soc_pkg::dev_slot_e    devtbl_slot_i,
	output logic                  sys_rst_o,
	output logic                  ram_rst_o,
	output logic                  gsr_o,
	output logic [`GPIOCOUNT-1:0] gp_o,
	output logic                  devtbl_vld_o,
	output logic [31:0]           devtbl_id_o,
	output logic                  devtbl_useintr_o,
	output logic [31:0]           devtbl_mapsz_o
);

	logic sys_rst_w;

	rst_sequencer #(
		.rst_cntr_bits     (rst_cntr_bits),
		.ram_rst_cntr_bits (ram_rst_cntr_bits)
	) u_rst (
		.clk200mhz_w   (clk200mhz_w),
		.rst_p         (rst_p),
		.pll_locked_i  (pll_locked_i),
		.swrst_i       (swrst_i),
		.cpu_rst_req_i (cpu_rst_req_i),
		.sys_rst_o     (sys_rst_w),
		.ram_rst_o     (ram_rst_o),
		.gsr_o         (gsr_o)
	);

	assign sys_rst_o = sys_rst_w;

	activity_blinker u_act (
		.clk200mhz_w     (clk200mhz_w),
		.rst_p           (rst_p),
		.sd_di_i         (sd_di_i),
		.sd_do_i         (sd_do_i),
		.dram_init_err_i (dram_init_err_i),
		.gpio_i          (gpio_i),
		.gp_o            (gp_o)
	);

	// Table reads are only served once the system is out of reset
	devtbl_rom u_devtbl (
		.clk200mhz_w (clk200mhz_w),
		.rst_p       (rst_p),
		.sys_rst_i   (sys_rst_w),
		.rd_i        (devtbl_rd_i),
		.slot_i      (devtbl_slot_i),
		.vld_o       (devtbl_vld_o),
		.id_o        (devtbl_id_o),
		.useintr_o   (devtbl_useintr_o),
		.mapsz_o     (devtbl_mapsz_o)
	);

endmodule

//--- soc_ctrl_assertions.sv
//****************************************
// Bound into every rst_sequencer instance
// fail_cnt is read by the testbench at the end of the run
//****************************************
module soc_ctrl_assertions (
	input logic            clk200mhz_w,
	input logic            rst_p,
	input soc_pkg::swrst_e swrst_i,
	input logic            ram_rst_i,
	input logic            gsr_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	int fail_cnt = 0;

	// RAM reset restarts from the external reset only
	ram_rise_a: assert property (@(posedge clk200mhz_w) $rose(ram_rst_i) |-> $past(rst_p))
		else begin
			$error("ram_rst_o rose without rst_p on the previous edge");
			fail_cnt++;
		end

	ram_reload_a: assert property (@(posedge clk200mhz_w) rst_p |=> ram_rst_i)
		else begin
			$error("ram_rst_o not active after rst_p");
			fail_cnt++;
		end

	gsr_cold_a: assert property (@(posedge clk200mhz_w) gsr_i == (swrst_i == SWRST_COLD))
		else begin
			$error("gsr_o does not follow the cold reset code");
			fail_cnt++;
		end

endmodule

bind rst_sequencer soc_ctrl_assertions u_asrt (
	.clk200mhz_w (clk200mhz_w),
	.rst_p       (rst_p),
	.swrst_i     (swrst_i),
	.ram_rst_i   (ram_rst_o),
	.gsr_i       (gsr_o)
);

//--- soc_ctrl_checker.sv
//****************************************
// Cycle model of the glue logic, compared on every rising edge
// Checks start on the edge after the first rst_p edge
//****************************************
`include "soc_consts.svh"

module soc_ctrl_checker #(
	parameter int cntr_bits = 6
) (
	input  logic                  clk200mhz_w,
	input  logic                  rst_p,
	input  logic                  pll_locked_i,
	input  soc_pkg::swrst_e       swrst_i,
	input  logic                  cpu_rst_req_i,
	input  logic                  sd_di_i,
	input  logic                  sd_do_i,
	input  logic                  dram_init_err_i,
	input  logic [`GPIOCOUNT-1:0] gpio_i,
	input  logic                  devtbl_rd_i,
	input  soc_pkg::dev_slot_e    devtbl_slot_i,
	input  logic                  sys_rst_i,
	input  logic                  ram_rst_i,
	input  logic                  gsr_i,
	input  logic [`GPIOCOUNT-1:0] gp_i,
	input  logic                  devtbl_vld_i,
	input  logic [31:0]           devtbl_id_i,
	input  logic                  devtbl_useintr_i,
	input  logic [31:0]           devtbl_mapsz_i,
	output int                    mismatch_cnt_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	int                              mismatch_cnt = 0;
	logic                            armed = 1'b0;
	logic                            have_entry = 1'b0;
	logic [cntr_bits-1:0]            sys_cnt;
	logic [cntr_bits-1:0]            ram_cnt;
	logic                            pwroff;
	logic                            led;
	logic [`ACTIVITY_CNTR_BITSZ-1:0] dim;
	logic                            vld;
	logic [64:0]                     entry;
	logic                            exp_sys_rst;

	assign mismatch_cnt_o = mismatch_cnt;

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
			mismatch_cnt++;
		end
	endtask

	// Packed as {useintr, id, mapsz}; BOOTLDR matches the invalid entry
	function automatic logic [64:0] table_entry(input logic [3:0] slot);
		case (slot)
			4'd0:    return {1'b1, 32'd4, 32'h0000_1000};
			4'd1:    return {1'b0, 32'd7, 32'h0000_1000};
			4'd2:    return {1'b1, 32'd6, 32'h0000_1000};
			4'd3:    return {1'b1, 32'd2, 32'h0000_1000};
			4'd4:    return {1'b0, 32'd3, 32'h0000_1000};
			4'd5:    return {1'b1, 32'd5, 32'h0000_1000};
			4'd6:    return {1'b0, 32'd1, 32'h4000_0000};
			4'd7:    return {1'b0, 32'd0, 32'h0001_0000};
			default: return {1'b0, 32'd0, 32'h0000_1000};
		endcase
	endfunction

	always @(posedge clk200mhz_w) begin
		exp_sys_rst = (sys_cnt != '0) || !pll_locked_i || pwroff;
		compare_value("gsr_o", 32'(gsr_i), 32'(swrst_i == SWRST_COLD));
		if (armed) begin
			compare_value("sys_rst_o", 32'(sys_rst_i), 32'(exp_sys_rst));
			compare_value("ram_rst_o", 32'(ram_rst_i), 32'(ram_cnt != '0));
			compare_value("gp_o", 32'(gp_i), 32'(gpio_i | `GPIOCOUNT'(led)));
			compare_value("devtbl_vld_o", 32'(devtbl_vld_i), 32'(vld));
			if (have_entry) begin
				compare_value("devtbl_useintr_o", 32'(devtbl_useintr_i), 32'(entry[64]));
				compare_value("devtbl_id_o", devtbl_id_i, entry[63:32]);
				compare_value("devtbl_mapsz_o", devtbl_mapsz_i, entry[31:0]);
			end
		end
		// Advance the model by one edge
		if (rst_p || cpu_rst_req_i || (swrst_i == SWRST_WARM)) begin
			sys_cnt = '1;
		end else if (sys_cnt != '0) begin
			sys_cnt--;
		end
		if (swrst_i == SWRST_PWROFF) begin
			pwroff = 1'b1;
		end else if (rst_p) begin
			pwroff = 1'b0;
		end
		if (rst_p) begin
			ram_cnt = '1;
		end else if (pll_locked_i && (ram_cnt != '0)) begin
			ram_cnt--;
		end
		if (rst_p) begin
			led = 1'b0;
			dim = '0;
		end else if (dim != '0) begin
			led = 1'b0;
			dim--;
		end else if (!sd_di_i || !sd_do_i || dram_init_err_i) begin
			led = 1'b1;
			dim = '1;
		end
		vld = devtbl_rd_i && !rst_p && !exp_sys_rst;
		if (vld) begin
			entry = table_entry(devtbl_slot_i);
			have_entry = 1'b1;
		end
		if (rst_p) begin
			armed = 1'b1;
		end
	end

endmodule

//--- soc_ctrl_tb.sv
//****************************************
// Countdown widths are set to 6, so a release takes 63 edges
// Inputs change on the falling edge
// Checks run in soc_ctrl_checker
//****************************************
`include "soc_consts.svh"

module soc_ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	localparam int CNTR_BITS  = 6;
	localparam int REL_EDGES  = 63;
	localparam int WAIT_LIMIT = 500;

	logic                  clk200mhz_w = 1'b0;
	logic                  rst_p;
	logic                  pll_locked_i;
	swrst_e                swrst_i;
	logic                  cpu_rst_req_i;
	logic                  sd_di_i;
	logic                  sd_do_i;
	logic                  dram_init_err_i;
	logic [`GPIOCOUNT-1:0] gpio_i;
	logic                  devtbl_rd_i;
	dev_slot_e             devtbl_slot_i;
	logic                  sys_rst_o;
	logic                  ram_rst_o;
	logic                  gsr_o;
	logic [`GPIOCOUNT-1:0] gp_o;
	logic                  devtbl_vld_o;
	logic [31:0]           devtbl_id_o;
	logic                  devtbl_useintr_o;
	logic [31:0]           devtbl_mapsz_o;
	int                    mismatch_cnt;
	int                    seq_errs = 0;
	logic [31:0]           seed = 32'hf015_4b0f;

	soc_ctrl_top #(
		.rst_cntr_bits     (CNTR_BITS),
		.ram_rst_cntr_bits (CNTR_BITS)
	) dut0 (.*);

	soc_ctrl_checker #(.cntr_bits(CNTR_BITS)) u_chk (
		.sys_rst_i        (sys_rst_o),
		.ram_rst_i        (ram_rst_o),
		.gsr_i            (gsr_o),
		.gp_i             (gp_o),
		.devtbl_vld_i     (devtbl_vld_o),
		.devtbl_id_i      (devtbl_id_o),
		.devtbl_useintr_i (devtbl_useintr_o),
		.devtbl_mapsz_i   (devtbl_mapsz_o),
		.mismatch_cnt_o   (mismatch_cnt),
		.*
	);

	initial begin
		forever #4 clk200mhz_w = ~clk200mhz_w;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// SD lines mostly idle high and DRAM errors are rare
	task automatic drive_background();
		logic [31:0] r;
		r = lcg_next();
		sd_di_i         = r[16] | r[17];
		sd_do_i         = r[18] | r[19];
		dram_init_err_i = (r[23:20] == 4'd0);
		gpio_i          = r[31:24];
		devtbl_rd_i     = r[1];
		devtbl_slot_i   = dev_slot_e'(r[7:4]);
	endtask

	// Counts edges until sys_rst_o drops, noting where ram_rst_o dropped
	task automatic wait_release(input bit check_ram, output bit ok);
		int edges;
		int ram_edges;
		edges = 0;
		ram_edges = 0;
		do begin
			@(negedge clk200mhz_w);
			edges++;
			if ((ram_edges == 0) && (ram_rst_o === 1'b0)) begin
				ram_edges = edges;
			end
			drive_background();
		end while ((sys_rst_o !== 1'b0) && (edges < WAIT_LIMIT));
		ok = (sys_rst_o === 1'b0);
		if (!ok) begin
			$display("Timeout: sys_rst_o still high after %0d edges", edges);
			seq_errs++;
		end else if (edges != REL_EDGES) begin
			$display("sys_rst_o released after %0d edges, not %0d", edges, REL_EDGES);
			seq_errs++;
		end
		if (ok && check_ram && (ram_edges != REL_EDGES)) begin
			$display("ram_rst_o released after %0d edges, not %0d", ram_edges, REL_EDGES);
			seq_errs++;
		end
	endtask

	task automatic read_slot(input logic [3:0] slot, output bit ok);
		int edges;
		edges = 0;
		devtbl_rd_i   = 1'b1;
		devtbl_slot_i = dev_slot_e'(slot);
		do begin
			@(negedge clk200mhz_w);
			edges++;
			devtbl_rd_i = 1'b0;
		end while ((devtbl_vld_o !== 1'b1) && (edges < WAIT_LIMIT));
		ok = (devtbl_vld_o === 1'b1);
		if (!ok) begin
			$display("Timeout: no valid pulse for a read of slot %0d", slot);
			seq_errs++;
		end else if (edges != 1) begin
			$display("Valid pulse for slot %0d came %0d edges after the read", slot, edges);
			seq_errs++;
		end
	endtask

	task automatic run_tests();
		bit          ok;
		logic [31:0] r;
		repeat (4) @(negedge clk200mhz_w);
		rst_p = 1'b0;
		wait_release(1'b1, ok);
		if (!ok) return;
		// Sweep every index including those that fold to the invalid device
		for (int s = 0; s < 16; s++) begin
			read_slot(4'(s), ok);
			if (!ok) return;
		end
		repeat (6) begin
			r = lcg_next();
			if (r[0]) begin
				swrst_i = SWRST_WARM;
			end else begin
				cpu_rst_req_i = 1'b1;
			end
			repeat (1 + int'(r[11:8])) @(negedge clk200mhz_w);
			swrst_i       = SWRST_NONE;
			cpu_rst_req_i = 1'b0;
			wait_release(1'b0, ok);
			if (!ok) return;
		end
		// Power-off holds until an external reset
		swrst_i = SWRST_PWROFF;
		repeat (2) @(negedge clk200mhz_w);
		swrst_i = SWRST_NONE;
		r = lcg_next();
		repeat (20 + int'(r[5:0])) begin
			@(negedge clk200mhz_w);
			drive_background();
		end
		rst_p = 1'b1;
		@(negedge clk200mhz_w);
		rst_p = 1'b0;
		wait_release(1'b1, ok);
		if (!ok) return;
		pll_locked_i = 1'b0;
		repeat (1 + int'(r[8:6])) @(negedge clk200mhz_w);
		pll_locked_i = 1'b1;
		repeat (2000) begin
			@(negedge clk200mhz_w);
			drive_background();
			r = lcg_next();
			swrst_i       = (r[31:24] == 8'd0) ? SWRST_WARM :
				((r[9:8] == 2'd0) ? SWRST_COLD : SWRST_NONE);
			cpu_rst_req_i = (r[23:16] == 8'd0);
			pll_locked_i  = (r[15:10] != 6'd0);
		end
		repeat (2) @(negedge clk200mhz_w);
	endtask

	task automatic end_run();
		int asrt_errs;
		asrt_errs = dut0.u_rst.u_asrt.fail_cnt;
		$display("Errors: %0d mismatches, %0d sequence errors, %0d assertion failures",
			mismatch_cnt, seq_errs, asrt_errs);
		if ((mismatch_cnt == 0) && (seq_errs == 0) && (asrt_errs == 0)) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	initial begin
		rst_p           = 1'b1;
		pll_locked_i    = 1'b1;
		swrst_i         = SWRST_NONE;
		cpu_rst_req_i   = 1'b0;
		sd_di_i         = 1'b1;
		sd_do_i         = 1'b1;
		dram_init_err_i = 1'b0;
		gpio_i          = '0;
		devtbl_rd_i     = 1'b0;
		devtbl_slot_i   = SLOT_SDCARD;
		run_tests();
		end_run();
	end

endmodule

//--- soc_ctrl_top.f
+incdir+.
soc_pkg.sv
rst_sequencer.sv
activity_blinker.sv
devtbl_rom.sv
soc_ctrl_top.sv
soc_ctrl_assertions.sv
soc_ctrl_checker.sv
soc_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the soc_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--timescale 1ns/1ps \
	--top-module soc_ctrl_tb \
	-f soc_ctrl_top.f \
	-o soc_ctrl_sim || exit 1

out=$(./obj_dir/soc_ctrl_sim +verilator+error+limit+100)
echo "$out"

echo "$out" | grep -q "^Regression passed$" && exit 0 || exit 1
